//--- Makefile
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = tb_stream_ctl
FILELIST = all.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

sim: build
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- all.f
design/stream_ctl_pkg.sv
design/op_decode.sv
design/mem_grant_fsm.sv
design/lane_stream_fsm.sv
design/sync_collect.sv
design/stream_ctl_top.sv
verification/stream_ctl_checker.sv
verification/tb_stream_ctl.sv

//--- design/lane_stream_fsm.sv
// lane stream sequencer: DMA write, streaming operator, then DMA read enables
`timescale 1ns/1ns

module lane_stream_fsm
(
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 strm_enable,
  input  logic                                 lane_active,
  input  stream_ctl_pkg::op_cfg_t              op,
  input  logic [stream_ctl_pkg::PE_ID_W-1:0]   pe_id,
  input  logic                                 all_synchronized,
  input  stream_ctl_pkg::lane_status_t         status,
  output stream_ctl_pkg::lane_ctl_t            ctl,
  output stream_ctl_pkg::lane_state_e          state
);

  stream_ctl_pkg::lane_state_e state_next;

  logic [stream_ctl_pkg::NUM_STREAMS-1:0] need_write;
  logic [stream_ctl_pkg::NUM_STREAMS-1:0] need_stop;
  logic [stream_ctl_pkg::NUM_STREAMS-1:0] need_read;
  logic stop_all_ready;
  logic units_done;

  // --------------------------------------------------
  // per-stream enable conditions
  // --------------------------------------------------
  always_comb
  begin
    // operator streams follow the source count
    need_stop[0] = (op.num_src_streams >= 2'd1);
    need_stop[1] = (op.num_src_streams == 2'd2);
    for (int k = 0; k < stream_ctl_pkg::NUM_STREAMS; k++)
    begin
      need_write[k] = (op.dst[k] == stream_ctl_pkg::DST_MEMORY);
      // local memory reads only, remote data arrives another way
      need_read[k]  = (op.src[k] == stream_ctl_pkg::SRC_MEMORY) && (op.rd_pe_id[k] == pe_id);
    end
  end

  // readiness checked against the streams this op needs
  assign stop_all_ready = &(~need_stop | status.stop_ready);

  // every enabled unit reported done
  assign units_done = (&(~ctl.stop_enable | status.stop_complete)) &&
                      (&(~ctl.read_enable | status.read_complete)) &&
                      (&(~ctl.write_enable | status.write_complete));

  // --------------------------------------------------
  // next state
  // --------------------------------------------------
  always_comb
  begin
    case (state)
      stream_ctl_pkg::LN_WAIT:
        state_next = (strm_enable && lane_active) ? stream_ctl_pkg::LN_EN_DMA_WRITE :
                                                    stream_ctl_pkg::LN_WAIT;
      stream_ctl_pkg::LN_EN_DMA_WRITE:
        state_next = stream_ctl_pkg::LN_EN_STOP;
      stream_ctl_pkg::LN_EN_STOP:
        state_next = stop_all_ready ? stream_ctl_pkg::LN_EN_DMA_READ : stream_ctl_pkg::LN_EN_STOP;
      stream_ctl_pkg::LN_EN_DMA_READ:
        state_next = stream_ctl_pkg::LN_OP_START;
      stream_ctl_pkg::LN_OP_START:
        state_next = units_done ? stream_ctl_pkg::LN_WAIT_SYNC : stream_ctl_pkg::LN_OP_START;
      // system-wide sync across all pes
      stream_ctl_pkg::LN_WAIT_SYNC:
        state_next = all_synchronized ? stream_ctl_pkg::LN_COMPLETE :
                                        stream_ctl_pkg::LN_WAIT_SYNC;
      stream_ctl_pkg::LN_COMPLETE:
        state_next = strm_enable ? stream_ctl_pkg::LN_COMPLETE : stream_ctl_pkg::LN_WAIT;
      default:
        state_next = stream_ctl_pkg::LN_WAIT;
    endcase
  end

  // --------------------------------------------------
  // state and enable registers
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= stream_ctl_pkg::LN_WAIT;
      ctl   <= '0;
    end
    else
    begin
      state <= state_next;
      // latch stream routing and dma write enables
      if (state == stream_ctl_pkg::LN_EN_DMA_WRITE)
      begin
        ctl.src          <= op.src;
        ctl.dst          <= op.dst;
        ctl.opcode       <= op.opcode;
        ctl.write_enable <= ctl.write_enable | need_write;
      end
      if (state == stream_ctl_pkg::LN_EN_STOP)
        ctl.stop_enable <= ctl.stop_enable | need_stop;
      if (state == stream_ctl_pkg::LN_EN_DMA_READ)
        ctl.read_enable <= ctl.read_enable | need_read;
      // dma enables drop at completion
      if (state == stream_ctl_pkg::LN_COMPLETE)
      begin
        ctl.read_enable  <= '0;
        ctl.write_enable <= '0;
      end
      // operators stay up until the lane is idle
      if (state == stream_ctl_pkg::LN_WAIT)
        ctl.stop_enable <= '0;
    end
  end

  // read dma only ever targets this pe's memory
  for (genvar k = 0; k < stream_ctl_pkg::NUM_STREAMS; k++)
  begin : g_rd_chk
    a_read_local: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(ctl.read_enable[k]) |-> $past(op.rd_pe_id[k] == pe_id));
  end

endmodule

//--- design/mem_grant_fsm.sv
// memory grant FSM: request, grant and release of the memory controller
`timescale 1ns/1ns

module mem_grant_fsm
(
  input  logic clk,
  input  logic rst_n,
  input  logic enable,
  input  logic mem_granted,
  input  logic lanes_done,
  output logic mem_request,
  output logic mem_released,
  output logic ready,
  output logic complete,
  output logic strm_enable
);

  stream_ctl_pkg::ctl_state_e state;
  stream_ctl_pkg::ctl_state_e state_next;

  logic mem_request_next;
  logic mem_released_next;
  logic in_wait;
  logic in_op_init;
  logic in_complete;

  // --------------------------------------------------
  // next state
  // --------------------------------------------------
  always_comb
  begin
    case (state)
      stream_ctl_pkg::CTL_WAIT:
        state_next = enable ? stream_ctl_pkg::CTL_MEM_REQ : stream_ctl_pkg::CTL_WAIT;
      // hold request until memory controller answers
      stream_ctl_pkg::CTL_MEM_REQ:
        state_next = !enable     ? stream_ctl_pkg::CTL_RELEASE_MEM :
                     mem_granted ? stream_ctl_pkg::CTL_MEM_GRANTED :
                                   stream_ctl_pkg::CTL_MEM_REQ;
      stream_ctl_pkg::CTL_MEM_GRANTED:
        state_next = !enable ? stream_ctl_pkg::CTL_RELEASE_MEM : stream_ctl_pkg::CTL_OP_INIT;
      // lanes run here, leave once all active lanes finish
      stream_ctl_pkg::CTL_OP_INIT:
        state_next = (!enable || lanes_done) ? stream_ctl_pkg::CTL_RELEASE_MEM :
                                               stream_ctl_pkg::CTL_OP_INIT;
      // wait for grant to drop
      stream_ctl_pkg::CTL_RELEASE_MEM:
        state_next = !mem_granted ? stream_ctl_pkg::CTL_COMPLETE :
                                    stream_ctl_pkg::CTL_RELEASE_MEM;
      stream_ctl_pkg::CTL_COMPLETE:
        state_next = enable ? stream_ctl_pkg::CTL_COMPLETE : stream_ctl_pkg::CTL_WAIT;
      default:
        state_next = stream_ctl_pkg::CTL_WAIT;
    endcase
  end

  // state decodes for the flags
  assign in_wait     = (state == stream_ctl_pkg::CTL_WAIT);
  assign in_op_init  = (state == stream_ctl_pkg::CTL_OP_INIT);
  assign in_complete = (state == stream_ctl_pkg::CTL_COMPLETE);

  // request from enable in wait through op init
  assign mem_request_next = (in_wait && enable) ||
                            (state == stream_ctl_pkg::CTL_MEM_REQ) ||
                            (state == stream_ctl_pkg::CTL_MEM_GRANTED) || in_op_init;
  // released while idle and once memory is handed back, drops with the request
  assign mem_released_next = (in_wait && !enable) || in_complete ||
                             (state == stream_ctl_pkg::CTL_RELEASE_MEM);

  // --------------------------------------------------
  // state and flag registers
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state        <= stream_ctl_pkg::CTL_WAIT;
      mem_request  <= 1'b0;
      mem_released <= 1'b1;
      ready        <= 1'b0;
      complete     <= 1'b0;
      strm_enable  <= 1'b0;
    end
    else
    begin
      state        <= state_next;
      mem_request  <= mem_request_next;
      mem_released <= mem_released_next;
      // set/clear flags, cleared only back in wait
      if (in_wait)
      begin
        ready       <= 1'b0;
        complete    <= 1'b0;
        strm_enable <= 1'b0;
      end
      else
      begin
        if (in_op_init)
        begin
          ready       <= 1'b1;
          strm_enable <= 1'b1;
        end
        if (in_complete)
          complete <= 1'b1;
      end
    end
  end

  // memory is either requested or released, except while held
  a_req_or_rel: assert property (@(posedge clk) disable iff (!rst_n)
    !(state inside {stream_ctl_pkg::CTL_MEM_GRANTED, stream_ctl_pkg::CTL_OP_INIT})
      |-> (mem_request || mem_released));

  // complete lags the state by one cycle, so it may linger into wait
  a_complete_state: assert property (@(posedge clk) disable iff (!rst_n)
    complete |-> (state inside {stream_ctl_pkg::CTL_COMPLETE, stream_ctl_pkg::CTL_WAIT}));

  a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
    state inside {stream_ctl_pkg::CTL_WAIT, stream_ctl_pkg::CTL_MEM_REQ,
                  stream_ctl_pkg::CTL_MEM_GRANTED, stream_ctl_pkg::CTL_OP_INIT,
                  stream_ctl_pkg::CTL_RELEASE_MEM, stream_ctl_pkg::CTL_COMPLETE});

endmodule

//--- design/op_decode.sv
// command decoder: registers rs0/rs1 and slices them into the operation struct
`timescale 1ns/1ns

module op_decode
(
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [stream_ctl_pkg::CMD_W-1:0]    rs0,
  input  logic [stream_ctl_pkg::CMD_W-1:0]    rs1,
  output stream_ctl_pkg::op_cfg_t             op
);

  logic [stream_ctl_pkg::CMD_W-1:0] q_rs0;
  logic [stream_ctl_pkg::CMD_W-1:0] q_rs1;

  // command words sampled every cycle
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      q_rs0 <= '0;
      q_rs1 <= '0;
    end
    else
    begin
      q_rs0 <= rs0;
      q_rs1 <= rs1;
    end
  end

  // --------------------------------------------------
  // field slicing
  // --------------------------------------------------
  always_comb
  begin
    op.enable          = q_rs0[stream_ctl_pkg::RS0_EN_BIT];
    op.lane_active     = q_rs1[stream_ctl_pkg::RS1_MASK_LSB +: stream_ctl_pkg::NUM_LANES];
    op.opcode          = stream_ctl_pkg::opcode_e'(
                           q_rs0[stream_ctl_pkg::RS0_OPC_LSB +: stream_ctl_pkg::OPC_W]);
    op.num_src_streams = q_rs0[stream_ctl_pkg::RS0_NSRC_LSB +: stream_ctl_pkg::NSRC_W];
    // stream source codes
    op.src[0] = stream_ctl_pkg::src_sel_e'(
                  q_rs0[stream_ctl_pkg::RS0_SRC0_LSB +: stream_ctl_pkg::SEL_W]);
    op.src[1] = stream_ctl_pkg::src_sel_e'(
                  q_rs0[stream_ctl_pkg::RS0_SRC1_LSB +: stream_ctl_pkg::SEL_W]);
    // stream destination codes
    op.dst[0] = stream_ctl_pkg::dst_sel_e'(
                  q_rs0[stream_ctl_pkg::RS0_DST0_LSB +: stream_ctl_pkg::SEL_W]);
    op.dst[1] = stream_ctl_pkg::dst_sel_e'(
                  q_rs0[stream_ctl_pkg::RS0_DST1_LSB +: stream_ctl_pkg::SEL_W]);
    // pe holding the read data of each stream
    op.rd_pe_id[0] = q_rs1[stream_ctl_pkg::RS1_PEID0_LSB +: stream_ctl_pkg::PE_ID_W];
    op.rd_pe_id[1] = q_rs1[stream_ctl_pkg::RS1_PEID1_LSB +: stream_ctl_pkg::PE_ID_W];
  end

  // core never issues three source streams, operators only handle two
  a_nsrc_legal: assert property (@(posedge clk) disable iff (!rst_n)
    op.enable |-> (op.num_src_streams != 2'd3));

endmodule

//--- design/stream_ctl_pkg.sv
// stream controller package: sizes, command layout, enums and structs
package stream_ctl_pkg;

  // --------------------------------------------------
  // sizes
  // --------------------------------------------------
  localparam int NUM_LANES   = 4;
  localparam int NUM_STREAMS = 2;
  localparam int PE_ID_W     = 8;
  localparam int CMD_W       = 32;
  localparam int SEL_W       = 2;
  localparam int OPC_W       = 4;
  localparam int NSRC_W      = 2;

  // rs0 field positions
  localparam int RS0_EN_BIT   = 0;
  localparam int RS0_OPC_LSB  = 1;
  localparam int RS0_NSRC_LSB = 5;
  localparam int RS0_SRC0_LSB = 7;
  localparam int RS0_SRC1_LSB = 9;
  localparam int RS0_DST0_LSB = 11;
  localparam int RS0_DST1_LSB = 13;

  // rs1 field positions
  localparam int RS1_MASK_LSB  = 0;
  localparam int RS1_PEID0_LSB = 8;
  localparam int RS1_PEID1_LSB = 16;

  // --------------------------------------------------
  // encodings
  // --------------------------------------------------
  typedef enum logic [SEL_W-1:0] {SRC_NONE, SRC_MEMORY, SRC_NOC} src_sel_e;
  typedef enum logic [SEL_W-1:0] {DST_NONE, DST_MEMORY, DST_NOC} dst_sel_e;
  typedef enum logic [OPC_W-1:0] {OP_NOP = 4'd0, OP_BSUM = 4'd1} opcode_e;

  // main memory-grant FSM
  typedef enum logic [2:0] {
    CTL_WAIT, CTL_MEM_REQ, CTL_MEM_GRANTED, CTL_OP_INIT, CTL_RELEASE_MEM, CTL_COMPLETE
  } ctl_state_e;

  // per-lane stream sequencer
  typedef enum logic [2:0] {
    LN_WAIT, LN_EN_DMA_WRITE, LN_EN_STOP, LN_EN_DMA_READ, LN_OP_START, LN_WAIT_SYNC,
    LN_COMPLETE
  } lane_state_e;

  // --------------------------------------------------
  // structs
  // --------------------------------------------------
  typedef struct packed {
    logic                                 enable;
    logic [NUM_LANES-1:0]                 lane_active;
    opcode_e                              opcode;
    logic [NSRC_W-1:0]                    num_src_streams;
    src_sel_e [NUM_STREAMS-1:0]           src;
    dst_sel_e [NUM_STREAMS-1:0]           dst;
    logic [NUM_STREAMS-1:0][PE_ID_W-1:0]  rd_pe_id;
  } op_cfg_t;

  // controls to one lane of the datapath
  typedef struct packed {
    logic [NUM_STREAMS-1:0]     stop_enable;
    logic [NUM_STREAMS-1:0]     read_enable;
    logic [NUM_STREAMS-1:0]     write_enable;
    src_sel_e [NUM_STREAMS-1:0] src;
    dst_sel_e [NUM_STREAMS-1:0] dst;
    opcode_e                    opcode;
  } lane_ctl_t;

  // status back from one lane
  typedef struct packed {
    logic [NUM_STREAMS-1:0] stop_ready;
    logic [NUM_STREAMS-1:0] stop_complete;
    logic [NUM_STREAMS-1:0] read_complete;
    logic [NUM_STREAMS-1:0] write_complete;
  } lane_status_t;

endpackage

//--- design/stream_ctl_top.sv
// stream controller top: decode, memory grant, lane sequencers and sync collect
`timescale 1ns/1ns

module stream_ctl_top
(
  input  logic                                                       clk,
  input  logic                                                       rst_n,
  input  logic [stream_ctl_pkg::CMD_W-1:0]                           rs0,
  input  logic [stream_ctl_pkg::CMD_W-1:0]                           rs1,
  input  logic [stream_ctl_pkg::PE_ID_W-1:0]                         pe_id,
  input  logic                                                       all_synchronized,
  input  logic                                                       mem_granted,
  input  stream_ctl_pkg::lane_status_t [stream_ctl_pkg::NUM_LANES-1:0] lane_status,
  output logic                                                       ready,
  output logic                                                       complete,
  output logic                                                       this_synchronized,
  output logic                                                       mem_request,
  output logic                                                       mem_released,
  output stream_ctl_pkg::lane_ctl_t [stream_ctl_pkg::NUM_LANES-1:0]  lane_ctl
);

  stream_ctl_pkg::op_cfg_t                                   op;
  stream_ctl_pkg::lane_state_e [stream_ctl_pkg::NUM_LANES-1:0] lane_state;
  logic strm_enable;
  logic lanes_done;

  // --------------------------------------------------
  // decode and memory acquisition
  // --------------------------------------------------
  op_decode u_op_decode
  (
    .clk (clk),
    .rst_n (rst_n),
    .rs0 (rs0),
    .rs1 (rs1),
    .op (op)
  );

  mem_grant_fsm u_mem_grant_fsm
  (
    .clk (clk),
    .rst_n (rst_n),
    .enable (op.enable),
    .mem_granted (mem_granted),
    .lanes_done (lanes_done),
    .mem_request (mem_request),
    .mem_released (mem_released),
    .ready (ready),
    .complete (complete),
    .strm_enable (strm_enable)
  );

  // --------------------------------------------------
  // one sequencer per execution lane
  // --------------------------------------------------
  for (genvar i = 0; i < stream_ctl_pkg::NUM_LANES; i++)
  begin : g_lane
    lane_stream_fsm u_lane_stream_fsm
    (
      .clk (clk),
      .rst_n (rst_n),
      .strm_enable (strm_enable),
      .lane_active (op.lane_active[i]),
      .op (op),
      .pe_id (pe_id),
      .all_synchronized (all_synchronized),
      .status (lane_status[i]),
      .ctl (lane_ctl[i]),
      .state (lane_state[i])
    );
  end

  sync_collect u_sync_collect
  (
    .clk (clk),
    .rst_n (rst_n),
    .lane_active (op.lane_active),
    .lane_state (lane_state),
    .this_synchronized (this_synchronized),
    .lanes_done (lanes_done)
  );

endmodule

//--- design/sync_collect.sv
// sync collector: merges lane states into synchronized and all-lanes-done levels
`timescale 1ns/1ns

module sync_collect
(
  input  logic                                                     clk,
  input  logic                                                     rst_n,
  input  logic [stream_ctl_pkg::NUM_LANES-1:0]                     lane_active,
  input  stream_ctl_pkg::lane_state_e [stream_ctl_pkg::NUM_LANES-1:0] lane_state,
  output logic                                                     this_synchronized,
  output logic                                                     lanes_done
);

  logic [stream_ctl_pkg::NUM_LANES-1:0] lane_synced;
  logic [stream_ctl_pkg::NUM_LANES-1:0] lane_done;

  // inactive lanes count as finished
  always_comb
  begin
    for (int i = 0; i < stream_ctl_pkg::NUM_LANES; i++)
    begin
      lane_synced[i] = !lane_active[i] ||
                       (lane_state[i] inside {stream_ctl_pkg::LN_WAIT_SYNC,
                                              stream_ctl_pkg::LN_COMPLETE});
      lane_done[i]   = !lane_active[i] || (lane_state[i] == stream_ctl_pkg::LN_COMPLETE);
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      this_synchronized <= 1'b0;
      lanes_done        <= 1'b0;
    end
    else
    begin
      this_synchronized <= &lane_synced;
      lanes_done        <= &lane_done;
    end
  end

endmodule

//--- verification/stream_ctl_checker.sv
// stream controller checker: reference enables and comparing process
`timescale 1ns/1ns

module stream_ctl_checker
(
  input logic                                           clk,
  input logic                                           rst_n,
  input logic [stream_ctl_pkg::CMD_W-1:0]               rs0,
  input logic [stream_ctl_pkg::CMD_W-1:0]               rs1,
  input logic [stream_ctl_pkg::PE_ID_W-1:0]             pe_id,
  input logic                                           all_synchronized,
  input logic                                           mem_granted,
  input stream_ctl_pkg::lane_status_t [stream_ctl_pkg::NUM_LANES-1:0] lane_status,
  input logic                                           ready,
  input logic                                           complete,
  input logic                                           this_synchronized,
  input logic                                           mem_request,
  input logic                                           mem_released,
  input stream_ctl_pkg::lane_ctl_t [stream_ctl_pkg::NUM_LANES-1:0] lane_ctl
);

  int error_count = 0;
  logic reset_seen = 1'b0;
  logic enables_checked = 1'b0;
  logic seen_ready = 1'b0;
  logic seen_sync = 1'b0;
  logic prev_complete = 1'b0;
  logic prev_request = 1'b0;

  // expected stop/read/write enables of one lane, straight from the command words
  function automatic logic [5:0] expected_enables(input logic [31:0] c0, input logic [31:0] c1,
                                                  input logic [7:0] pe, input int lane);
    logic [1:0] stop;
    logic [1:0] rd;
    logic [1:0] wr;
    logic [1:0] nsrc;
    int src_lsb;
    int dst_lsb;
    int pe_lsb;
    stop = '0;
    rd = '0;
    wr = '0;
    nsrc = c0[stream_ctl_pkg::RS0_NSRC_LSB +: 2];
    if (c1[stream_ctl_pkg::RS1_MASK_LSB + lane])
    begin
      stop[0] = (nsrc >= 2'd1);
      stop[1] = (nsrc == 2'd2);
      for (int k = 0; k < 2; k++)
      begin
        src_lsb = (k == 0) ? stream_ctl_pkg::RS0_SRC0_LSB : stream_ctl_pkg::RS0_SRC1_LSB;
        dst_lsb = (k == 0) ? stream_ctl_pkg::RS0_DST0_LSB : stream_ctl_pkg::RS0_DST1_LSB;
        pe_lsb  = (k == 0) ? stream_ctl_pkg::RS1_PEID0_LSB : stream_ctl_pkg::RS1_PEID1_LSB;
        wr[k] = (c0[dst_lsb +: 2] == 2'd1);
        rd[k] = (c0[src_lsb +: 2] == 2'd1) && (c1[pe_lsb +: 8] == pe);
      end
    end
    return {stop, rd, wr};
  endfunction

  // latched routing of an active lane, src pair, dst pair, then opcode
  function automatic logic [11:0] expected_route(input logic [31:0] c0);
    return {c0[stream_ctl_pkg::RS0_SRC1_LSB +: 2], c0[stream_ctl_pkg::RS0_SRC0_LSB +: 2],
            c0[stream_ctl_pkg::RS0_DST1_LSB +: 2], c0[stream_ctl_pkg::RS0_DST0_LSB +: 2],
            c0[stream_ctl_pkg::RS0_OPC_LSB +: 4]};
  endfunction

  task automatic compare(input string test, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      $display("Mismatch %s: expected %h, actual %h", test, exp, act);
      error_count++;
    end
  endtask

  // --------------------------------------------------
  // comparing process, sampled on the rising edge before the flops move
  // --------------------------------------------------
  always @(posedge clk)
  begin
    logic [5:0] exp_en;
    logic [5:0] act_en;
    logic pending;
    if (rst_n)
    begin
      if (!reset_seen)
      begin
        reset_seen = 1'b1;
        compare("reset ready", 0, ready);
        compare("reset complete", 0, complete);
        compare("reset mem_request", 0, mem_request);
        compare("reset mem_released", 1, mem_released);
        for (int i = 0; i < stream_ctl_pkg::NUM_LANES; i++)
          compare($sformatf("reset enables lane %0d", i), 0,
                  {lane_ctl[i].stop_enable, lane_ctl[i].read_enable, lane_ctl[i].write_enable});
      end
      // released drops together with a new request
      if (mem_request && !prev_request)
        compare("released at request", 0, mem_released);
      prev_request = mem_request;
      // memory held while streaming
      if (ready && mem_request)
        compare("released while ready", 0, mem_released);
      if (ready)
        seen_ready = 1'b1;
      if (all_synchronized)
        seen_sync = 1'b1;
      if (ready && this_synchronized && !enables_checked)
      begin
        enables_checked = 1'b1;
        for (int i = 0; i < stream_ctl_pkg::NUM_LANES; i++)
        begin
          exp_en = expected_enables(rs0, rs1, pe_id, i);
          act_en = {lane_ctl[i].stop_enable, lane_ctl[i].read_enable, lane_ctl[i].write_enable};
          compare($sformatf("enables lane %0d", i), exp_en, act_en);
          if (rs1[stream_ctl_pkg::RS1_MASK_LSB + i])
            compare($sformatf("routing lane %0d", i), expected_route(rs0),
                    {lane_ctl[i].src, lane_ctl[i].dst, lane_ctl[i].opcode});
          // no enabled unit still busy at sync
          pending = |(lane_ctl[i].stop_enable & ~lane_status[i].stop_complete) ||
                    |(lane_ctl[i].read_enable & ~lane_status[i].read_complete) ||
                    |(lane_ctl[i].write_enable & ~lane_status[i].write_complete);
          compare($sformatf("units done at sync lane %0d", i), 0, pending);
        end
      end
      if (complete && !prev_complete)
      begin
        compare("complete mem_request", 0, mem_request);
        compare("complete mem_released", 1, mem_released);
        compare("complete mem_granted", 0, mem_granted);
        if (seen_ready)
          compare("complete after all_synchronized", 1, seen_sync);
      end
      prev_complete = complete;
      // idle again, new operation may start
      if (!ready && !complete && !mem_request)
      begin
        enables_checked = 1'b0;
        seen_ready = 1'b0;
        seen_sync = 1'b0;
      end
    end
  end

endmodule

//--- verification/tb_stream_ctl.sv
// stream controller testbench: clock, reset, LFSR stimulus, lane and memory responders
`timescale 1ns/1ns

module tb_stream_ctl;

  localparam int NL = stream_ctl_pkg::NUM_LANES;
  localparam int NS = stream_ctl_pkg::NUM_STREAMS;
  localparam int WAIT_LIMIT = 400;
  localparam logic [7:0] LOCAL_PE = 8'h2c;

  logic clk;
  logic rst_n;
  logic [stream_ctl_pkg::CMD_W-1:0] rs0;
  logic [stream_ctl_pkg::CMD_W-1:0] rs1;
  logic [stream_ctl_pkg::PE_ID_W-1:0] pe_id;
  logic all_synchronized;
  logic mem_granted;
  stream_ctl_pkg::lane_status_t [NL-1:0] lane_status;
  logic ready;
  logic complete;
  logic this_synchronized;
  logic mem_request;
  logic mem_released;
  stream_ctl_pkg::lane_ctl_t [NL-1:0] lane_ctl;

  logic [31:0] lfsr;
  int timeout_count;
  int grant_delay;
  int grant_cnt;
  int rdy_delay;
  int rdy_cnt;
  // delays and counters per lane, unit 0 stop, 1 read, 2 write
  int unit_delay [NL][3*NS];
  int unit_cnt [NL][3*NS];

  stream_ctl_top u_stream_ctl_top
  (
    .clk (clk),
    .rst_n (rst_n),
    .rs0 (rs0),
    .rs1 (rs1),
    .pe_id (pe_id),
    .all_synchronized (all_synchronized),
    .mem_granted (mem_granted),
    .lane_status (lane_status),
    .ready (ready),
    .complete (complete),
    .this_synchronized (this_synchronized),
    .mem_request (mem_request),
    .mem_released (mem_released),
    .lane_ctl (lane_ctl)
  );

  stream_ctl_checker u_checker
  (
    .clk (clk),
    .rst_n (rst_n),
    .rs0 (rs0),
    .rs1 (rs1),
    .pe_id (pe_id),
    .all_synchronized (all_synchronized),
    .mem_granted (mem_granted),
    .lane_status (lane_status),
    .ready (ready),
    .complete (complete),
    .this_synchronized (this_synchronized),
    .mem_request (mem_request),
    .mem_released (mem_released),
    .lane_ctl (lane_ctl)
  );

  always #50 clk = ~clk;

  // --------------------------------------------------
  // random source
  // --------------------------------------------------
  // galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0])
      n = n ^ 32'h8020_0003;
    return n;
  endfunction

  // one step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int b = 0; b < n; b++)
    begin
      lfsr = lfsr_next(lfsr);
      v[b] = lfsr[0];
    end
  endtask

  // --------------------------------------------------
  // responders, all on the falling edge
  // --------------------------------------------------
  always @(negedge clk)
  begin
    logic en;
    if (rst_n)
    begin
      // grant some cycles after request, drop once request falls
      if (mem_request && !mem_granted)
      begin
        grant_cnt = grant_cnt + 1;
        if (grant_cnt >= grant_delay)
          mem_granted = 1'b1;
      end
      else
        grant_cnt = 0;
      if (mem_granted && !mem_request)
        mem_granted = 1'b0;
      all_synchronized = this_synchronized && ready;
      // enabled operators report ready once streaming starts
      rdy_cnt = ready ? rdy_cnt + 1 : 0;
      for (int i = 0; i < NL; i++)
      begin
        lane_status[i].stop_ready = (ready && rdy_cnt >= rdy_delay) ?
                                    lane_ctl[i].stop_enable : '0;
        for (int u = 0; u < 3*NS; u++)
        begin
          case (u / NS)
            0: en = lane_ctl[i].stop_enable[u % NS];
            1: en = lane_ctl[i].read_enable[u % NS];
            default: en = lane_ctl[i].write_enable[u % NS];
          endcase
          unit_cnt[i][u] = en ? unit_cnt[i][u] + 1 : 0;
          case (u / NS)
            0: lane_status[i].stop_complete[u % NS] = en && unit_cnt[i][u] >= unit_delay[i][u];
            1: lane_status[i].read_complete[u % NS] = en && unit_cnt[i][u] >= unit_delay[i][u];
            default:
              lane_status[i].write_complete[u % NS] = en && unit_cnt[i][u] >= unit_delay[i][u];
          endcase
        end
      end
    end
  end

  // --------------------------------------------------
  // bounded waits
  // --------------------------------------------------
  function automatic logic probe(input int which);
    case (which)
      0: return mem_request;
      1: return ready;
      2: return complete;
      default: return mem_released;
    endcase
  endfunction

  task automatic wait_level(input int which, input logic level, input string what);
    int cycles;
    cycles = 0;
    while (probe(which) !== level && cycles < WAIT_LIMIT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (probe(which) !== level)
    begin
      $display("timeout: %s did not reach %0b within %0d cycles", what, level, WAIT_LIMIT);
      timeout_count++;
    end
  endtask

  // pick one random command, the pe ids either local or remote
  task automatic build_command(output logic [31:0] c0, output logic [31:0] c1);
    logic [31:0] v;
    c0 = '0;
    c1 = '0;
    c0[stream_ctl_pkg::RS0_EN_BIT] = 1'b1;
    c0[stream_ctl_pkg::RS0_OPC_LSB +: 4] = 4'd1;
    draw_bits(4, v);
    c1[stream_ctl_pkg::RS1_MASK_LSB +: 4] = v[3:0];
    draw_bits(2, v);
    c0[stream_ctl_pkg::RS0_NSRC_LSB +: 2] = (v[1:0] == 2'd3) ? 2'd2 : v[1:0];
    draw_bits(2, v);
    c0[stream_ctl_pkg::RS0_SRC0_LSB +: 2] = v[1:0] % 2'd3;
    draw_bits(2, v);
    c0[stream_ctl_pkg::RS0_SRC1_LSB +: 2] = v[1:0] % 2'd3;
    draw_bits(2, v);
    c0[stream_ctl_pkg::RS0_DST0_LSB +: 2] = v[1:0] % 2'd3;
    draw_bits(2, v);
    c0[stream_ctl_pkg::RS0_DST1_LSB +: 2] = v[1:0] % 2'd3;
    draw_bits(1, v);
    c1[stream_ctl_pkg::RS1_PEID0_LSB +: 8] = v[0] ? LOCAL_PE : (LOCAL_PE ^ 8'h5a);
    draw_bits(1, v);
    c1[stream_ctl_pkg::RS1_PEID1_LSB +: 8] = v[0] ? LOCAL_PE : (LOCAL_PE ^ 8'h81);
    draw_bits(3, v);
    grant_delay = v[2:0] + 1;
    draw_bits(3, v);
    rdy_delay = v[2:0];
    for (int i = 0; i < NL; i++)
      for (int u = 0; u < 3*NS; u++)
      begin
        draw_bits(3, v);
        unit_delay[i][u] = v[2:0];
      end
  endtask

  // drop the command and let the controller go idle
  task automatic return_idle();
    @(negedge clk);
    rs0 = '0;
    rs1 = '0;
    wait_level(2, 1'b0, "complete clear");
    wait_level(1, 1'b0, "ready clear");
    repeat (3) @(negedge clk);
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial
  begin
    logic [31:0] c0;
    logic [31:0] c1;
    clk = 1'b0;
    rst_n = 1'b0;
    rs0 = '0;
    rs1 = '0;
    pe_id = LOCAL_PE;
    all_synchronized = 1'b0;
    mem_granted = 1'b0;
    lane_status = '0;
    lfsr = 32'd90955;
    timeout_count = 0;
    grant_delay = 1;
    grant_cnt = 0;
    rdy_delay = 0;
    rdy_cnt = 0;
    for (int i = 0; i < NL; i++)
      for (int u = 0; u < 3*NS; u++)
      begin
        unit_delay[i][u] = 0;
        unit_cnt[i][u] = 0;
      end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (4) @(negedge clk);

    // full operations
    for (int n = 0; n < 16; n++)
    begin
      build_command(c0, c1);
      rs0 = c0;
      rs1 = c1;
      wait_level(0, 1'b1, "mem_request");
      wait_level(1, 1'b1, "ready");
      wait_level(2, 1'b1, "complete");
      return_idle();
    end

    // abort before the grant arrives
    build_command(c0, c1);
    grant_delay = 60;
    rs0 = c0;
    rs1 = c1;
    wait_level(0, 1'b1, "mem_request before abort");
    repeat (2) @(negedge clk);
    rs0 = '0;
    wait_level(2, 1'b1, "complete after abort");
    wait_level(3, 1'b1, "mem_released after abort");
    return_idle();

    $display("errors: %0d mismatches, %0d timeouts", u_checker.error_count, timeout_count);
    if (u_checker.error_count == 0 && timeout_count == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule
